// File: tb.f
hw/mh_cfg_pkg.sv
hw/mh_types_pkg.sv
hw/sync_fifo.sv
hw/mshr_store.sv
hw/miss_req_ctrl.sv
hw/refill_buffer.sv
hw/refill_ctrl.sv
hw/miss_handler.sv
verif/tb_miss_handler.sv

// File: Makefile
TOP := tb_miss_handler

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert --top-module $(TOP) -f tb.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: verif/tb_miss_handler.sv
/*
 * Directed testbench for the miss handler. A small memory model returns
 * LCG data per line and keeps it for the expected values. Every miss asks
 * for a core response, and sid follows tid mod 4. Stops at the first error.
 */
`timescale 1ns/1ns

module tb_miss_handler
    import mh_cfg_pkg::*;
    import mh_types_pkg::*;
();

    // The directed tests take roughly 150 cycles
    localparam int MAX_CYCLES = 2000;

    logic       clk_i;
    logic       rst_ni;
    logic       alloc_valid_i;
    alloc_req_t alloc_req_i;
    logic       alloc_ready_o;
    nline_t     check_nline_i;
    logic       check_hit_o;
    logic       mshr_empty_o;
    logic       mshr_full_o;
    logic       mem_req_valid_o;
    mem_req_t   mem_req_o;
    logic       mem_req_ready_i;
    logic       mem_resp_valid_i;
    mem_resp_t  mem_resp_i;
    logic       mem_resp_ready_o;
    logic       refill_req_o;
    logic       refill_gnt_i;
    logic       data_wr_valid_o;
    data_wr_t   data_wr_o;
    logic       dir_wr_valid_o;
    dir_wr_t    dir_wr_o;
    logic       core_rsp_valid_o;
    core_rsp_t  core_rsp_o;

    string       test_name = "init";
    int          cycle_cnt = 0;
    logic [31:0] lcg_state;
    chunk_t      line_data [4][4];
    data_wr_t    data_q [$];
    dir_wr_t     dir_q [$];
    core_rsp_t   rsp_q [$];

    miss_handler u_dut (.*);

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: no progress after %0d cycles in %s", cycle_cnt, test_name);
            $display("** FAIL **");
            $fatal(1, "Simulation timed out");
        end
    end

    // Record cache writes and core responses in mid cycle
    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (data_wr_valid_o) begin
                data_q.push_back(data_wr_o);
            end
            if (dir_wr_valid_o) begin
                dir_q.push_back(dir_wr_o);
            end
            if (core_rsp_valid_o) begin
                rsp_q.push_back(core_rsp_o);
            end
        end
    end

    task automatic check_val(input string what, input logic [127:0] exp,
                             input logic [127:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s, %s: expected %0h, actual %0h", test_name, what, exp, act);
            $display("** FAIL **");
            $fatal(1, "Mismatch in %s", test_name);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        check_val(what, 128'(exp), 128'(act));
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic allocate_miss(input nline_t nl, input tid_t tid, input word_idx_t word);
        alloc_req_t req;
        req.nline    = nl;
        req.tid      = tid;
        req.sid      = sid_t'(tid % 4);
        req.word     = word;
        req.need_rsp = 1'b1;
        @(posedge clk_i);
        alloc_valid_i <= 1'b1;
        alloc_req_i   <= req;
        do @(negedge clk_i); while (!alloc_ready_o);
        @(posedge clk_i);
        alloc_valid_i <= 1'b0;
    endtask

    // Memory side holds ready low for a while before taking the read
    task automatic serve_mem_req(input nline_t nl, input mem_id_t id);
        mem_req_t first;
        do @(negedge clk_i); while (!mem_req_valid_o);
        first = mem_req_o;
        check_val("mem address", 128'(32'(nl) * 32'd64), 128'(first.addr));
        check_val("mem id", 128'(id), 128'(first.id));
        repeat (3) begin
            @(negedge clk_i);
            check_bit("mem_req_valid_o held", 1'b1, mem_req_valid_o);
            check_val("mem request stable", 128'(first), 128'(mem_req_o));
            check_bit("alloc_ready_o while sending", 1'b0, alloc_ready_o);
        end
        @(posedge clk_i);
        mem_req_ready_i <= 1'b1;
        @(posedge clk_i);
        mem_req_ready_i <= 1'b0;
        @(negedge clk_i);
        check_bit("mem_req_valid_o after ready", 1'b0, mem_req_valid_o);
    endtask

    // Sends one line of four beats. A negative err_beat means no error
    task automatic return_line(input mem_id_t id, input int err_beat);
        mem_resp_t beat;
        for (int i = 0; i < CHUNKS_PER_LINE; i++) begin
            line_data[id][i] = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
            beat.data  = line_data[id][i];
            beat.id    = id;
            beat.error = (i == err_beat);
            beat.last  = (i == CHUNKS_PER_LINE - 1);
            @(posedge clk_i);
            mem_resp_valid_i <= 1'b1;
            mem_resp_i       <= beat;
            do @(negedge clk_i); while (!mem_resp_ready_o);
        end
        @(posedge clk_i);
        mem_resp_valid_i <= 1'b0;
    endtask

    task automatic check_pending(input nline_t nl, input logic exp);
        @(posedge clk_i);
        check_nline_i <= nl;
        @(negedge clk_i);
        check_bit("check_hit_o", exp, check_hit_o);
    endtask

    task automatic wait_drained(input int n_rsp);
        do @(negedge clk_i); while (!(mshr_empty_o && rsp_q.size() >= n_rsp));
    endtask

    // Word w of a line is half w mod 2 of chunk w div 2
    task automatic check_line(input nline_t nl, input mem_id_t id, input tid_t tid,
                              input word_idx_t word, input logic err);
        data_wr_t  dw;
        dir_wr_t   dr;
        core_rsp_t rsp;
        chunk_t    ch;
        if (!err) begin
            for (int i = 0; i < CHUNKS_PER_LINE; i++) begin
                check_bit("data write present", 1'b1, data_q.size() > 0);
                dw = data_q.pop_front();
                check_val("data write set", 128'(cache_set_t'(nl % 64)), 128'(dw.set));
                check_val("data write index", 128'(i), 128'(dw.idx));
                check_val("data write data", line_data[id][i], dw.data);
            end
            check_bit("directory write present", 1'b1, dir_q.size() > 0);
            dr = dir_q.pop_front();
            check_val("directory set", 128'(cache_set_t'(nl % 64)), 128'(dr.set));
            check_val("directory tag", 128'(cache_tag_t'(nl / 64)), 128'(dr.tag));
        end
        check_bit("core response present", 1'b1, rsp_q.size() > 0);
        rsp = rsp_q.pop_front();
        check_val("core tid", 128'(tid), 128'(rsp.tid));
        check_val("core sid", 128'(sid_t'(tid % 4)), 128'(rsp.sid));
        check_bit("core error", err, rsp.error);
        if (!err) begin
            ch = line_data[id][word / 2];
            check_val("core data", 128'(word[0] ? ch[127:64] : ch[63:0]), 128'(rsp.data));
        end
    endtask

    task automatic check_no_writes();
        check_val("leftover data writes", 128'(0), 128'(data_q.size()));
        check_val("leftover directory writes", 128'(0), 128'(dir_q.size()));
        check_val("leftover core responses", 128'(0), 128'(rsp_q.size()));
    endtask

    task automatic reset_state();
        test_name = "reset_state";
        @(negedge clk_i);
        check_bit("alloc_ready_o", 1'b1, alloc_ready_o);
        check_bit("mshr_empty_o", 1'b1, mshr_empty_o);
        check_bit("mshr_full_o", 1'b0, mshr_full_o);
        check_bit("mem_req_valid_o", 1'b0, mem_req_valid_o);
        check_bit("refill_req_o", 1'b0, refill_req_o);
        check_bit("data_wr_valid_o", 1'b0, data_wr_valid_o);
        check_bit("dir_wr_valid_o", 1'b0, dir_wr_valid_o);
        check_bit("core_rsp_valid_o", 1'b0, core_rsp_valid_o);
    endtask

    task automatic miss_request();
        test_name = "miss_request";
        allocate_miss(26'h1234567, 6'h11, 3'd5);
        serve_mem_req(26'h1234567, 2'b01);
        check_pending(26'h1234567, 1'b1);
        // Same MSHR set, different line
        check_pending(26'h1234565, 1'b0);
    endtask

    task automatic refill_line();
        test_name = "refill_line";
        return_line(2'b01, -1);
        @(negedge clk_i);
        check_bit("refill_req_o", 1'b1, refill_req_o);
        check_val("writes before grant", 128'(0), 128'(data_q.size()));
        @(posedge clk_i);
        refill_gnt_i <= 1'b1;
        wait_drained(1);
        check_line(26'h1234567, 2'b01, 6'h11, 3'd5, 1'b0);
        check_no_writes();
        check_pending(26'h1234567, 1'b0);
        check_bit("mshr_empty_o", 1'b1, mshr_empty_o);
    endtask

    task automatic error_refill();
        test_name = "error_refill";
        allocate_miss(26'h2222222, 6'h22, 3'd2);
        serve_mem_req(26'h2222222, 2'b00);
        return_line(2'b00, 2);
        wait_drained(1);
        check_line(26'h2222222, 2'b00, 6'h22, 3'd2, 1'b1);
        check_no_writes();
        check_pending(26'h2222222, 1'b0);
    endtask

    task automatic occupancy();
        test_name = "occupancy";
        allocate_miss(26'h0a3c2e4, 6'h01, 3'd0);
        serve_mem_req(26'h0a3c2e4, 2'b00);
        allocate_miss(26'h15d0016, 6'h02, 3'd3);
        serve_mem_req(26'h15d0016, 2'b10);
        // A third line of MSHR set 0 finds both ways taken
        @(posedge clk_i);
        alloc_req_i.nline <= 26'h2000008;
        @(negedge clk_i);
        check_bit("alloc_ready_o with set 0 full", 1'b0, alloc_ready_o);
        allocate_miss(26'h0b7e123, 6'h03, 3'd6);
        serve_mem_req(26'h0b7e123, 2'b01);
        allocate_miss(26'h3fffff1, 6'h04, 3'd1);
        serve_mem_req(26'h3fffff1, 2'b11);
        check_bit("mshr_full_o", 1'b1, mshr_full_o);
        return_line(2'b11, -1);
        return_line(2'b01, -1);
        return_line(2'b10, -1);
        return_line(2'b00, -1);
        wait_drained(4);
        check_line(26'h3fffff1, 2'b11, 6'h04, 3'd1, 1'b0);
        check_line(26'h0b7e123, 2'b01, 6'h03, 3'd6, 1'b0);
        check_line(26'h15d0016, 2'b10, 6'h02, 3'd3, 1'b0);
        check_line(26'h0a3c2e4, 2'b00, 6'h01, 3'd0, 1'b0);
        check_no_writes();
        check_bit("mshr_empty_o", 1'b1, mshr_empty_o);
    endtask

    task automatic back_pressure();
        test_name = "back_pressure";
        @(posedge clk_i);
        refill_gnt_i <= 1'b0;
        allocate_miss(26'h0f0f0f0, 6'h3a, 3'd7);
        serve_mem_req(26'h0f0f0f0, 2'b00);
        allocate_miss(26'h0f0f0f1, 6'h05, 3'd0);
        serve_mem_req(26'h0f0f0f1, 2'b01);
        return_line(2'b00, -1);
        return_line(2'b01, -1);
        // Two whole lines fill the data FIFO
        repeat (3) begin
            @(negedge clk_i);
            check_bit("mem_resp_ready_o with two lines held", 1'b0, mem_resp_ready_o);
            check_bit("refill_req_o", 1'b1, refill_req_o);
            check_bit("data write without grant", 1'b0, data_wr_valid_o);
        end
        check_no_writes();
        @(posedge clk_i);
        refill_gnt_i <= 1'b1;
        wait_drained(2);
        check_line(26'h0f0f0f0, 2'b00, 6'h3a, 3'd7, 1'b0);
        check_line(26'h0f0f0f1, 2'b01, 6'h05, 3'd0, 1'b0);
        check_no_writes();
        check_bit("mshr_empty_o", 1'b1, mshr_empty_o);
        check_bit("mem_resp_ready_o after drain", 1'b1, mem_resp_ready_o);
    endtask

    initial begin
        clk_i            = 1'b0;
        rst_ni           = 1'b0;
        alloc_valid_i    = 1'b0;
        alloc_req_i      = '0;
        check_nline_i    = '0;
        mem_req_ready_i  = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_resp_i       = '0;
        refill_gnt_i     = 1'b0;
        lcg_state        = 32'hd29b;
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        reset_state();
        miss_request();
        refill_line();
        error_refill();
        occupancy();
        back_pressure();
        $display("** PASS **");
        $finish;
    end

endmodule

// File: hw/miss_handler.sv
/*
 * Miss handler for a non-blocking data cache. Misses are accepted one
 * per request round trip; refills may return in any order but their
 * beats must not interleave. The cache chooses the victim way itself.
 */
`timescale 1ns/1ns

module miss_handler
    import mh_cfg_pkg::*;
    import mh_types_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       alloc_valid_i,
    input  alloc_req_t alloc_req_i,
    output logic       alloc_ready_o,
    input  nline_t     check_nline_i,
    output logic       check_hit_o,
    output logic       mshr_empty_o,
    output logic       mshr_full_o,
    output logic       mem_req_valid_o,
    output mem_req_t   mem_req_o,
    input  logic       mem_req_ready_i,
    input  logic       mem_resp_valid_i,
    input  mem_resp_t  mem_resp_i,
    output logic       mem_resp_ready_o,
    output logic       refill_req_o,
    input  logic       refill_gnt_i,
    output logic       data_wr_valid_o,
    output data_wr_t   data_wr_o,
    output logic       dir_wr_valid_o,
    output dir_wr_t    dir_wr_o,
    output logic       core_rsp_valid_o,
    output core_rsp_t  core_rsp_o
);

    mshr_entry_t  alloc_entry;
    logic         set_free;
    mshr_way_t    alloc_way;
    logic         alloc;
    logic         ack;
    mem_id_t      ack_id;
    mshr_entry_t  ack_entry;
    logic         store_empty;
    logic         refill_busy;
    logic         meta_valid;
    refill_meta_t meta;
    logic         meta_pop;
    chunk_t       chunk;
    logic         chunk_pop;

    assign alloc_entry = '{
        nline:    alloc_req_i.nline,
        tid:      alloc_req_i.tid,
        sid:      alloc_req_i.sid,
        word:     alloc_req_i.word,
        need_rsp: alloc_req_i.need_rsp
    };

    // No miss pending and no refill in flight
    assign mshr_empty_o = store_empty && !refill_busy;

    mshr_store u_mshr_store (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .check_nline_i (check_nline_i),
        .check_hit_o   (check_hit_o),
        .alloc_i       (alloc),
        .alloc_entry_i (alloc_entry),
        .alloc_free_o  (set_free),
        .alloc_way_o   (alloc_way),
        .ack_i         (ack),
        .ack_id_i      (ack_id),
        .ack_entry_o   (ack_entry),
        .empty_o       (store_empty),
        .full_o        (mshr_full_o)
    );

    miss_req_ctrl u_miss_req_ctrl (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .alloc_valid_i   (alloc_valid_i),
        .alloc_nline_i   (alloc_req_i.nline),
        .set_free_i      (set_free),
        .alloc_way_i     (alloc_way),
        .alloc_ready_o   (alloc_ready_o),
        .alloc_o         (alloc),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o),
        .mem_req_ready_i (mem_req_ready_i)
    );

    refill_buffer u_refill_buffer (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_i       (mem_resp_i),
        .mem_resp_ready_o (mem_resp_ready_o),
        .meta_valid_o     (meta_valid),
        .meta_o           (meta),
        .meta_pop_i       (meta_pop),
        .chunk_o          (chunk),
        .chunk_pop_i      (chunk_pop)
    );

    refill_ctrl u_refill_ctrl (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .meta_valid_i     (meta_valid),
        .meta_i           (meta),
        .meta_pop_o       (meta_pop),
        .chunk_i          (chunk),
        .chunk_pop_o      (chunk_pop),
        .ack_o            (ack),
        .ack_id_o         (ack_id),
        .ack_entry_i      (ack_entry),
        .refill_req_o     (refill_req_o),
        .refill_gnt_i     (refill_gnt_i),
        .busy_o           (refill_busy),
        .data_wr_valid_o  (data_wr_valid_o),
        .data_wr_o        (data_wr_o),
        .dir_wr_valid_o   (dir_wr_valid_o),
        .dir_wr_o         (dir_wr_o),
        .core_rsp_valid_o (core_rsp_valid_o),
        .core_rsp_o       (core_rsp_o)
    );

endmodule

// File: hw/refill_ctrl.sv
/*
 * Writes one buffered line into the cache once the arbiter grants it.
 * The MSHR entry is read and freed on the grant edge, then one chunk is
 * written per cycle. A failed refill writes nothing but still answers
 * the core, with the error flag set.
 */
`timescale 1ns/1ns

module refill_ctrl
    import mh_cfg_pkg::*;
    import mh_types_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         meta_valid_i,
    input  refill_meta_t meta_i,
    output logic         meta_pop_o,
    input  chunk_t       chunk_i,
    output logic         chunk_pop_o,
    output logic         ack_o,
    output mem_id_t      ack_id_o,
    input  mshr_entry_t  ack_entry_i,
    output logic         refill_req_o,
    input  logic         refill_gnt_i,
    output logic         busy_o,
    output logic         data_wr_valid_o,
    output data_wr_t     data_wr_o,
    output logic         dir_wr_valid_o,
    output dir_wr_t      dir_wr_o,
    output logic         core_rsp_valid_o,
    output core_rsp_t    core_rsp_o
);

    typedef enum logic {
        RF_IDLE,
        RF_WRITE
    } refill_state_e;

    refill_state_e state_q;
    refill_state_e state_d;
    chunk_idx_t    cnt_q;
    chunk_idx_t    cnt_d;
    mshr_entry_t   entry_q;
    logic          grant;
    logic          last_chunk;
    logic          rsp_hit;
    logic          rsp_valid_q;
    core_rsp_t     rsp_q;

    assign refill_req_o = (state_q == RF_IDLE) && meta_valid_i;
    assign grant        = refill_req_o && refill_gnt_i;
    assign busy_o       = (state_q != RF_IDLE);
    assign last_chunk   = (cnt_q == chunk_idx_t'(CHUNKS_PER_LINE - 1));

    assign ack_o    = grant;
    assign ack_id_o = meta_i.id;

    assign data_wr_o.set  = entry_q.nline[CACHE_SET_W-1:0];
    assign data_wr_o.idx  = cnt_q;
    assign data_wr_o.data = chunk_i;
    assign dir_wr_o.set   = entry_q.nline[CACHE_SET_W-1:0];
    assign dir_wr_o.tag   = entry_q.nline[CACHE_SET_W +: CACHE_TAG_W];

    always_comb begin
        state_d         = state_q;
        cnt_d           = cnt_q;
        chunk_pop_o     = 1'b0;
        meta_pop_o      = 1'b0;
        data_wr_valid_o = 1'b0;
        dir_wr_valid_o  = 1'b0;
        case (state_q)
            RF_IDLE: begin
                if (grant) begin
                    cnt_d   = '0;
                    state_d = RF_WRITE;
                end
            end
            RF_WRITE: begin
                chunk_pop_o     = 1'b1;
                data_wr_valid_o = !meta_i.error;
                cnt_d           = cnt_q + 1'b1;
                // Directory goes with the last chunk, metadata leaves with it
                if (last_chunk) begin
                    dir_wr_valid_o = !meta_i.error;
                    meta_pop_o     = 1'b1;
                    state_d        = RF_IDLE;
                end
            end
            default: state_d = RF_IDLE;
        endcase
    end

    // Requested word lives in chunk word / WORDS_PER_CHUNK
    assign rsp_hit = (state_q == RF_WRITE) && entry_q.need_rsp &&
                     (cnt_q == chunk_idx_t'(entry_q.word >> $clog2(WORDS_PER_CHUNK)));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= RF_IDLE;
            cnt_q       <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            cnt_q       <= cnt_d;
            rsp_valid_q <= rsp_hit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (grant) begin
            entry_q <= ack_entry_i;
        end
        if (rsp_hit) begin
            rsp_q.data  <= chunk_i[entry_q.word[$clog2(WORDS_PER_CHUNK)-1:0] * WORD_W +: WORD_W];
            rsp_q.tid   <= entry_q.tid;
            rsp_q.sid   <= entry_q.sid;
            rsp_q.error <= meta_i.error;
        end
    end

    assign core_rsp_valid_o = rsp_valid_q;
    assign core_rsp_o       = rsp_q;

endmodule

// File: hw/refill_buffer.sv
/*
 * Buffers refill beats and one metadata record per line. Beats of
 * different lines must not interleave. Metadata is pushed with the last
 * beat, so a line is announced only once all its data is stored.
 */
`timescale 1ns/1ns

module refill_buffer
    import mh_cfg_pkg::*;
    import mh_types_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         mem_resp_valid_i,
    input  mem_resp_t    mem_resp_i,
    output logic         mem_resp_ready_o,
    output logic         meta_valid_o,
    output refill_meta_t meta_o,
    input  logic         meta_pop_i,
    output chunk_t       chunk_o,
    input  logic         chunk_pop_i
);

    logic         data_full;
    logic         meta_full;
    logic         meta_empty;
    logic         beat_accept;
    logic         err_q;
    refill_meta_t meta_wdata;

    // The last beat needs room in both FIFOs
    assign mem_resp_ready_o = !data_full && (!mem_resp_i.last || !meta_full);
    assign beat_accept      = mem_resp_valid_i && mem_resp_ready_o;

    assign meta_wdata.id    = mem_resp_i.id;
    assign meta_wdata.error = err_q | mem_resp_i.error;
    assign meta_valid_o     = !meta_empty;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            err_q <= 1'b0;
        end else if (beat_accept) begin
            err_q <= mem_resp_i.last ? 1'b0 : meta_wdata.error;
        end
    end

    sync_fifo #(
        .DEPTH  (DATA_FIFO_DEPTH),
        .data_t (chunk_t)
    ) u_data_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (beat_accept),
        .wdata_i (mem_resp_i.data),
        .full_o  (data_full),
        .pop_i   (chunk_pop_i),
        .empty_o (),
        .rdata_o (chunk_o)
    );

    sync_fifo #(
        .DEPTH  (META_FIFO_DEPTH),
        .data_t (refill_meta_t)
    ) u_meta_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (beat_accept && mem_resp_i.last),
        .wdata_i (meta_wdata),
        .full_o  (meta_full),
        .pop_i   (meta_pop_i),
        .empty_o (meta_empty),
        .rdata_o (meta_o)
    );

endmodule

// File: hw/miss_req_ctrl.sv
/*
 * Accepts one miss at a time and issues its line read to memory.
 * No new miss is taken until the read has been handed over.
 */
`timescale 1ns/1ns

module miss_req_ctrl
    import mh_cfg_pkg::*;
    import mh_types_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      alloc_valid_i,
    input  nline_t    alloc_nline_i,
    input  logic      set_free_i,
    input  mshr_way_t alloc_way_i,
    output logic      alloc_ready_o,
    output logic      alloc_o,
    output logic      mem_req_valid_o,
    output mem_req_t  mem_req_o,
    input  logic      mem_req_ready_i
);

    typedef enum logic {
        REQ_IDLE,
        REQ_SEND
    } req_state_e;

    req_state_e state_q;
    nline_t     nline_q;
    mshr_way_t  way_q;

    assign alloc_ready_o   = (state_q == REQ_IDLE) && set_free_i;
    assign alloc_o         = alloc_valid_i && alloc_ready_o;
    assign mem_req_valid_o = (state_q == REQ_SEND);

    assign mem_req_o.addr = {nline_q, {LINE_OFFSET_W{1'b0}}};
    assign mem_req_o.id   = {way_q, nline_q[MSHR_SET_W-1:0]};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= REQ_IDLE;
        end else if (alloc_o) begin
            state_q <= REQ_SEND;
        end else if (mem_req_ready_i && state_q == REQ_SEND) begin
            state_q <= REQ_IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_o) begin
            nline_q <= alloc_nline_i;
            way_q   <= alloc_way_i;
        end
    end

endmodule

// File: hw/mshr_store.sv
/*
 * MSHR entries, indexed by the low bit of the line number and a way.
 * Check and free-way lookup are combinational. An entry is valid from
 * the edge after allocation and freed on the acknowledge edge.
 */
`timescale 1ns/1ns

module mshr_store
    import mh_cfg_pkg::*;
    import mh_types_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  nline_t      check_nline_i,
    output logic        check_hit_o,
    input  logic        alloc_i,
    input  mshr_entry_t alloc_entry_i,
    output logic        alloc_free_o,
    output mshr_way_t   alloc_way_o,
    input  logic        ack_i,
    input  mem_id_t     ack_id_i,
    output mshr_entry_t ack_entry_o,
    output logic        empty_o,
    output logic        full_o
);

    logic [MSHR_SETS-1:0][MSHR_WAYS-1:0] valid_q;
    mshr_entry_t entry_q [MSHR_SETS][MSHR_WAYS];

    mshr_set_t check_set;
    mshr_set_t alloc_set;
    mshr_set_t ack_set;
    mshr_way_t ack_way;

    assign check_set = check_nline_i[MSHR_SET_W-1:0];
    assign alloc_set = alloc_entry_i.nline[MSHR_SET_W-1:0];
    assign ack_set   = ack_id_i[MSHR_SET_W-1:0];
    assign ack_way   = ack_id_i[MSHR_SET_W +: MSHR_WAY_W];

    always_comb begin
        check_hit_o = 1'b0;
        for (int w = 0; w < MSHR_WAYS; w++) begin
            if (valid_q[check_set][w] && entry_q[check_set][w].nline == check_nline_i) begin
                check_hit_o = 1'b1;
            end
        end
    end

    // Walk down so the lowest free way wins
    always_comb begin
        alloc_free_o = 1'b0;
        alloc_way_o  = '0;
        for (int w = MSHR_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[alloc_set][w]) begin
                alloc_free_o = 1'b1;
                alloc_way_o  = mshr_way_t'(w);
            end
        end
    end

    assign ack_entry_o = entry_q[ack_set][ack_way];
    assign empty_o     = ~|valid_q;
    assign full_o      = &valid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            if (alloc_i) begin
                valid_q[alloc_set][alloc_way_o] <= 1'b1;
            end
            if (ack_i) begin
                valid_q[ack_set][ack_way] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            entry_q[alloc_set][alloc_way_o] <= alloc_entry_i;
        end
    end

endmodule

// File: hw/sync_fifo.sv
/*
 * Register FIFO. DEPTH must be a power of two so the pointers wrap
 * on their own. Push while full and pop while empty are ignored.
 */
`timescale 1ns/1ns

module sync_fifo #(
    parameter int  DEPTH  = 4,
    parameter type data_t = logic
) (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  push_i,
    input  data_t wdata_i,
    output logic  full_o,
    input  logic  pop_i,
    output logic  empty_o,
    output data_t rdata_o
);

    data_t mem_q [DEPTH];

    logic [$clog2(DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(DEPTH)-1:0] rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0] count_q;
    logic do_push;
    logic do_pop;

    assign full_o  = (count_q == ($clog2(DEPTH+1))'(DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign rdata_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop keep the count
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= wdata_i;
        end
    end

endmodule

// File: hw/mh_types_pkg.sv
/*
 * Bundles exchanged between the miss handler blocks and its neighbours.
 * Addresses are byte addresses; line reads are always line aligned.
 */
package mh_types_pkg;
    import mh_cfg_pkg::*;

    typedef struct packed {
        nline_t    nline;
        tid_t      tid;
        sid_t      sid;
        word_idx_t word;
        logic      need_rsp;
    } alloc_req_t;

    typedef struct packed {
        logic [NLINE_W+LINE_OFFSET_W-1:0] addr;
        mem_id_t                          id;
    } mem_req_t;

    // One memory beat
    typedef struct packed {
        chunk_t  data;
        mem_id_t id;
        logic    error;
        logic    last;
    } mem_resp_t;

    // Per line, error is the OR over all beats
    typedef struct packed {
        mem_id_t id;
        logic    error;
    } refill_meta_t;

    typedef struct packed {
        nline_t    nline;
        tid_t      tid;
        sid_t      sid;
        word_idx_t word;
        logic      need_rsp;
    } mshr_entry_t;

    typedef struct packed {
        cache_set_t set;
        chunk_idx_t idx;
        chunk_t     data;
    } data_wr_t;

    typedef struct packed {
        cache_set_t set;
        cache_tag_t tag;
    } dir_wr_t;

    typedef struct packed {
        word_t data;
        tid_t  tid;
        sid_t  sid;
        logic  error;
    } core_rsp_t;

endpackage

// File: hw/mh_cfg_pkg.sv
/*
 * Geometry of the miss handler: 64-byte lines, 32-bit addresses,
 * a 2x2 MSHR store and 128-bit memory beats equal to the refill chunk.
 * Both FIFO depths must stay powers of two.
 */
package mh_cfg_pkg;

    localparam int LINE_OFFSET_W   = 6;
    localparam int NLINE_W         = 26;
    localparam int CACHE_SET_W     = 6;
    localparam int CACHE_TAG_W     = 20;
    localparam int MSHR_SETS       = 2;
    localparam int MSHR_WAYS       = 2;
    localparam int MSHR_SET_W      = $clog2(MSHR_SETS);
    localparam int MSHR_WAY_W      = $clog2(MSHR_WAYS);
    localparam int MEM_ID_W        = 2;
    localparam int CHUNK_W         = 128;
    localparam int CHUNKS_PER_LINE = 4;
    localparam int WORD_W          = 64;
    localparam int WORD_IDX_W      = 3;
    localparam int WORDS_PER_CHUNK = 2;
    localparam int TID_W           = 6;
    localparam int SID_W           = 2;
    // Room for two complete lines
    localparam int DATA_FIFO_DEPTH = 8;
    localparam int META_FIFO_DEPTH = 2;

    typedef logic [NLINE_W-1:0]                 nline_t;
    typedef logic [CACHE_SET_W-1:0]             cache_set_t;
    typedef logic [CACHE_TAG_W-1:0]             cache_tag_t;
    typedef logic [MSHR_SET_W-1:0]              mshr_set_t;
    typedef logic [MSHR_WAY_W-1:0]              mshr_way_t;
    // Identifier is {way, mshr set}
    typedef logic [MEM_ID_W-1:0]                mem_id_t;
    typedef logic [CHUNK_W-1:0]                 chunk_t;
    typedef logic [$clog2(CHUNKS_PER_LINE)-1:0] chunk_idx_t;
    typedef logic [WORD_W-1:0]                  word_t;
    typedef logic [WORD_IDX_W-1:0]              word_idx_t;
    typedef logic [TID_W-1:0]                   tid_t;
    typedef logic [SID_W-1:0]                   sid_t;

endpackage
